//--- Makefile
BUILD_DIR := build

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --assert --timing --top-module vector_lane_tb \
		--Mdir $(BUILD_DIR) -f vector_lane.f
	./$(BUILD_DIR)/Vvector_lane_tb

clean:
	rm -rf $(BUILD_DIR)

//--- hdl/elem_extract.sv
`timescale 1ns/1ps
`default_nettype none

module elem_extract
   import lane_pkg::*;
(
   input  logic              clk_i,
   input  logic              rst_i,

   // Word from the register file, one cycle after the request
   input  vreg_word_u        rdata_i,
   input  rd_req_t           req_i,
   input  logic [1:0]        sew_i,

   output logic [WORD_W-1:0] elem_o
);

   logic [1:0]        sel_q;
   logic [1:0]        sew_q;
   logic [WORD_W-1:0] elem_next;

   // Select and width follow the read, so they line up with the word
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         sel_q <= '0;
         sew_q <= SEW32;
      end else if (req_i.en) begin
         sel_q <= req_i.elem_sel;
         sew_q <= sew_i;
      end
   end

   // Zero-extended byte, halfword or whole word
   always_comb begin
      case (sew_q)
         SEW8: begin
            elem_next = {{(WORD_W - 8){1'b0}}, rdata_i.bytes[sel_q]};
         end
         SEW16: begin
            elem_next = {{(WORD_W - 16){1'b0}}, rdata_i.halves[sel_q[0]]};
         end
         SEW32: begin
            elem_next = rdata_i.word;
         end
         default: begin
            elem_next = '0;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      elem_o <= elem_next;
   end

endmodule

`default_nettype wire

//--- hdl/lane_pkg.sv
`default_nettype none

package lane_pkg;

   //////////////////////////////////////////////////
   // Lane sizes
   //////////////////////////////////////////////////
   localparam int R_PORTS        = 4;
   localparam int W_PORTS        = R_PORTS / 2;
   localparam int VRF_DEPTH      = 64;
   localparam int VRF_ADDR_W     = 6;
   localparam int MASK_DEPTH     = 32;
   localparam int MASK_ADDR_W    = 5;
   localparam int WORD_W         = 32;
   localparam int BE_W           = WORD_W / 8;
   localparam int ALU_CTRL_W     = 6;

   // Cycles from request to operand and from request to array write
   localparam int READ_LATENCY   = 2;
   localparam int COMMIT_LATENCY = 2;

   // Element width codes
   localparam logic [1:0] SEW8   = 2'd0;
   localparam logic [1:0] SEW16  = 2'd1;
   localparam logic [1:0] SEW32  = 2'd2;

   // Write data source
   localparam logic SRC_ALU      = 1'b0;
   localparam logic SRC_LOAD     = 1'b1;

   //////////////////////////////////////////////////
   // Types
   //////////////////////////////////////////////////

   // One register file word, seen whole or split by element width
   typedef union packed {
      logic [WORD_W-1:0]  word;
      logic [3:0][7:0]    bytes;
      logic [1:0][15:0]   halves;
   } vreg_word_u;

   typedef struct packed {
      logic                  en;
      logic [VRF_ADDR_W-1:0] addr;
      logic [1:0]            elem_sel;
   } rd_req_t;

   typedef struct packed {
      logic                  vld;
      logic [ALU_CTRL_W-1:0] opmode;
      logic [1:0]            read_sew;
      logic [1:0]            write_sew;
   } alu_req_t;

   typedef struct packed {
      logic [VRF_ADDR_W-1:0]  addr;
      logic [BE_W-1:0]        be;
      logic                   src_sel;
      logic                   masked;
      logic                   req_ctrl;
      logic                   mask_we;
      logic [MASK_ADDR_W-1:0] mask_addr;
   } wr_req_t;

endpackage

`default_nettype wire

//--- hdl/operand_issue.sv
`timescale 1ns/1ps
`default_nettype none

module operand_issue
   import lane_pkg::*;
(
   input  logic                                 clk_i,
   input  logic                                 rst_i,

   // Extracted elements, one per read port
   input  logic     [R_PORTS-1:0][WORD_W-1:0]   elem_i,
   input  alu_req_t [W_PORTS-1:0]               alu_req_i,

   // To the external ALU
   output logic     [W_PORTS-1:0][WORD_W-1:0]     vs1_data_o,
   output logic     [W_PORTS-1:0][WORD_W-1:0]     vs2_data_o,
   output logic     [W_PORTS-1:0][ALU_CTRL_W-1:0] alu_opmode_o,
   output logic     [W_PORTS-1:0][1:0]            alu_read_sew_o,
   output logic     [W_PORTS-1:0][1:0]            alu_write_sew_o,
   output logic     [W_PORTS-1:0]                 alu_vld_o
);

   alu_req_t [READ_LATENCY-1:0][W_PORTS-1:0] ctrl_q;

   // ALU control waits for the operands to come out of the read path
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         ctrl_q <= '0;
      end else begin
         ctrl_q[0] <= alu_req_i;
         for (int s = 1; s < READ_LATENCY; s++) begin
            ctrl_q[s] <= ctrl_q[s-1];
         end
      end
   end

   // Ports 2j and 2j+1 feed write port j
   always_comb begin
      for (int j = 0; j < W_PORTS; j++) begin
         vs1_data_o[j]      = elem_i[2*j];
         vs2_data_o[j]      = elem_i[2*j+1];
         alu_opmode_o[j]    = ctrl_q[READ_LATENCY-1][j].opmode;
         alu_read_sew_o[j]  = ctrl_q[READ_LATENCY-1][j].read_sew;
         alu_write_sew_o[j] = ctrl_q[READ_LATENCY-1][j].write_sew;
         alu_vld_o[j]       = ctrl_q[READ_LATENCY-1][j].vld;
      end
   end

endmodule

`default_nettype wire

//--- hdl/vector_lane.sv
`timescale 1ns/1ps
`default_nettype none

module vector_lane
   import lane_pkg::*;
(
   input  logic                                  clk_i,
   input  logic                                  rst_i,

   // Requests
   input  rd_req_t  [R_PORTS-1:0]                rd_req_i,
   input  alu_req_t [W_PORTS-1:0]                alu_req_i,
   input  wr_req_t  [W_PORTS-1:0]                wr_req_i,
   input  logic     [WORD_W-1:0]                 load_data_i,

   // Returning from the ALU
   input  logic     [W_PORTS-1:0]                alu_vld_i,
   input  logic     [W_PORTS-1:0][WORD_W-1:0]    alu_res_i,
   input  logic     [W_PORTS-1:0]                alu_mask_i,

   // Operands and control to the ALU
   output logic     [W_PORTS-1:0][WORD_W-1:0]     vs1_data_o,
   output logic     [W_PORTS-1:0][WORD_W-1:0]     vs2_data_o,
   output logic     [W_PORTS-1:0][ALU_CTRL_W-1:0] alu_opmode_o,
   output logic     [W_PORTS-1:0][1:0]            alu_read_sew_o,
   output logic     [W_PORTS-1:0][1:0]            alu_write_sew_o,
   output logic     [W_PORTS-1:0]                 alu_vld_o
);

   vreg_word_u [R_PORTS-1:0]                  rdata;
   logic       [R_PORTS-1:0][WORD_W-1:0]      elem_data;
   logic       [W_PORTS-1:0][VRF_ADDR_W-1:0]  waddr;
   logic       [W_PORTS-1:0][WORD_W-1:0]      wdata;
   logic       [W_PORTS-1:0][BE_W-1:0]        wbe;

   vreg_file u_vreg_file (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .rd_req_i (rd_req_i),
      .rdata_o  (rdata),
      .waddr_i  (waddr),
      .wdata_i  (wdata),
      .wbe_i    (wbe)
   );

   // Read ports 2j and 2j+1 take the read SEW of write port j
   for (genvar i = 0; i < R_PORTS; i++) begin : g_extract
      elem_extract u_elem_extract (
         .clk_i   (clk_i),
         .rst_i   (rst_i),
         .rdata_i (rdata[i]),
         .req_i   (rd_req_i[i]),
         .sew_i   (alu_req_i[i/2].read_sew),
         .elem_o  (elem_data[i])
      );
   end

   operand_issue u_operand_issue (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .elem_i          (elem_data),
      .alu_req_i       (alu_req_i),
      .vs1_data_o      (vs1_data_o),
      .vs2_data_o      (vs2_data_o),
      .alu_opmode_o    (alu_opmode_o),
      .alu_read_sew_o  (alu_read_sew_o),
      .alu_write_sew_o (alu_write_sew_o),
      .alu_vld_o       (alu_vld_o)
   );

   write_commit u_write_commit (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .wr_req_i    (wr_req_i),
      .load_data_i (load_data_i),
      .alu_vld_i   (alu_vld_i),
      .alu_res_i   (alu_res_i),
      .alu_mask_i  (alu_mask_i),
      .waddr_o     (waddr),
      .wdata_o     (wdata),
      .wbe_o       (wbe)
   );

endmodule

`default_nettype wire

//--- hdl/vreg_file.sv
`timescale 1ns/1ps
`default_nettype none

module vreg_file
   import lane_pkg::*;
(
   input  logic                                 clk_i,
   input  logic                                 rst_i,

   // Read ports
   input  rd_req_t    [R_PORTS-1:0]             rd_req_i,
   output vreg_word_u [R_PORTS-1:0]             rdata_o,

   // Write ports, already gated by the commit path
   input  logic       [W_PORTS-1:0][VRF_ADDR_W-1:0] waddr_i,
   input  logic       [W_PORTS-1:0][WORD_W-1:0]     wdata_i,
   input  logic       [W_PORTS-1:0][BE_W-1:0]       wbe_i
);

   logic [WORD_W-1:0] mem [VRF_DEPTH];

   //////////////////////////////////////////////////
   // Byte-enabled writes
   //////////////////////////////////////////////////

   // Later ports overwrite earlier ones, so the highest port wins per byte
   always_ff @(posedge clk_i) begin
      for (int p = 0; p < W_PORTS; p++) begin
         for (int b = 0; b < BE_W; b++) begin
            if (wbe_i[p][b]) begin
               mem[waddr_i[p]][b*8 +: 8] <= wdata_i[p][b*8 +: 8];
            end
         end
      end
   end

   //////////////////////////////////////////////////
   // Registered reads
   //////////////////////////////////////////////////

   // Idle port keeps its last word
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         rdata_o <= '0;
      end else begin
         for (int r = 0; r < R_PORTS; r++) begin
            if (rd_req_i[r].en) begin
               rdata_o[r] <= mem[rd_req_i[r].addr];
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- hdl/write_commit.sv
`timescale 1ns/1ps
`default_nettype none

module write_commit
   import lane_pkg::*;
(
   input  logic                                 clk_i,
   input  logic                                 rst_i,

   input  wr_req_t [W_PORTS-1:0]                wr_req_i,
   input  logic    [WORD_W-1:0]                 load_data_i,

   // Results returning from the ALU
   input  logic    [W_PORTS-1:0]                alu_vld_i,
   input  logic    [W_PORTS-1:0][WORD_W-1:0]    alu_res_i,
   input  logic    [W_PORTS-1:0]                alu_mask_i,

   // To the register file write ports
   output logic    [W_PORTS-1:0][VRF_ADDR_W-1:0] waddr_o,
   output logic    [W_PORTS-1:0][WORD_W-1:0]     wdata_o,
   output logic    [W_PORTS-1:0][BE_W-1:0]       wbe_o
);

   // One write port's request as it moves toward commit
   typedef struct packed {
      logic [VRF_ADDR_W-1:0]  addr;
      logic [WORD_W-1:0]      data;
      logic [BE_W-1:0]        be;
      logic                   masked;
      logic                   mask_bit;
      logic                   gate;
      logic                   mask_we;
      logic                   mask_data;
      logic [MASK_ADDR_W-1:0] mask_addr;
   } commit_t;

   commit_t [W_PORTS-1:0]                     pipe_d;
   commit_t [COMMIT_LATENCY-1:0][W_PORTS-1:0] pipe_q;
   commit_t [W_PORTS-1:0]                     head;
   logic    [MASK_DEPTH-1:0]                  mask_q;

   //////////////////////////////////////////////////
   // Request capture
   //////////////////////////////////////////////////

   // Source data, ALU status and the mask bit are all taken in the request cycle
   always_comb begin
      for (int j = 0; j < W_PORTS; j++) begin
         pipe_d[j].addr = wr_req_i[j].addr;
         case (wr_req_i[j].src_sel)
            SRC_ALU:  pipe_d[j].data = alu_res_i[j];
            SRC_LOAD: pipe_d[j].data = load_data_i;
         endcase
         pipe_d[j].be        = wr_req_i[j].be;
         pipe_d[j].masked    = wr_req_i[j].masked;
         pipe_d[j].mask_bit  = mask_q[wr_req_i[j].mask_addr];
         pipe_d[j].gate      = alu_vld_i[j] | wr_req_i[j].req_ctrl;
         pipe_d[j].mask_we   = wr_req_i[j].mask_we;
         pipe_d[j].mask_data = alu_mask_i[j];
         pipe_d[j].mask_addr = wr_req_i[j].mask_addr;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         pipe_q <= '0;
      end else begin
         pipe_q[0] <= pipe_d;
         for (int s = 1; s < COMMIT_LATENCY; s++) begin
            pipe_q[s] <= pipe_q[s-1];
         end
      end
   end

   assign head = pipe_q[COMMIT_LATENCY-1];

   //////////////////////////////////////////////////
   // Commit
   //////////////////////////////////////////////////

   // Nothing is written without ALU valid or request control;
   // a masked write also needs its mask bit
   always_comb begin
      for (int j = 0; j < W_PORTS; j++) begin
         waddr_o[j] = head[j].addr;
         wdata_o[j] = head[j].data;
         wbe_o[j]   = head[j].be & {BE_W{head[j].gate}}
                    & (head[j].masked ? {BE_W{head[j].mask_bit}} : {BE_W{1'b1}});
      end
   end

   // Mask register file, written in the same cycle as the word
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         mask_q <= '0;
      end else begin
         for (int j = 0; j < W_PORTS; j++) begin
            if (head[j].mask_we && head[j].gate) begin
               mask_q[head[j].mask_addr] <= head[j].mask_data;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- vector_lane.f
hdl/lane_pkg.sv
hdl/vreg_file.sv
hdl/elem_extract.sv
hdl/operand_issue.sv
hdl/write_commit.sv
hdl/vector_lane.sv
verif/vector_lane_asserts.sv
verif/vector_lane_tb.sv

//--- verif/vector_lane_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module vector_lane_asserts
   import lane_pkg::*;
(
   input logic                          clk_i,
   input logic                          rst_i,
   input alu_req_t [W_PORTS-1:0]        alu_req_i,
   input wr_req_t  [W_PORTS-1:0]        wr_req_i,
   input logic [W_PORTS-1:0]            issue_vld_i,
   input logic [W_PORTS-1:0][BE_W-1:0]  commit_be_i
);

   // Operand control is cleared by reset
   assert property (@(posedge clk_i) !rst_i |=> issue_vld_i == '0)
      else $error("alu_vld_o high in the cycle after reset");

   for (genvar j = 0; j < W_PORTS; j++) begin : g_port
      // Valid follows the request through both read stages
      assert property (@(posedge clk_i) $past(rst_i) && $past(rst_i, 2)
                       |-> issue_vld_i[j] == $past(alu_req_i[j].vld, 2))
         else $error("alu_vld_o[%0d] does not match the request two cycles back", j);

      // Bytes written at commit were requested two cycles back
      assert property (@(posedge clk_i) $past(rst_i) && $past(rst_i, 2)
                       |-> (commit_be_i[j] & ~$past(wr_req_i[j].be, 2)) == '0)
         else $error("byte enable on write port %0d without a write request", j);
   end

endmodule

bind vector_lane vector_lane_asserts u_vector_lane_asserts (
   .clk_i       (clk_i),
   .rst_i       (rst_i),
   .alu_req_i   (alu_req_i),
   .wr_req_i    (wr_req_i),
   .issue_vld_i (alu_vld_o),
   .commit_be_i (wbe)
);

`default_nettype wire

//--- verif/vector_lane_tb.sv
`timescale 1ns/1ps
`default_nettype none

module vector_lane_tb
   import lane_pkg::*;
();

   // Tests need about 650 cycles
   localparam int TIMEOUT_CYCLES = 5000;

   logic                                 clk_i;
   logic                                 rst_i;
   rd_req_t  [R_PORTS-1:0]               rd_req;
   alu_req_t [W_PORTS-1:0]               alu_req;
   wr_req_t  [W_PORTS-1:0]               wr_req;
   logic     [WORD_W-1:0]                load_data;
   logic     [W_PORTS-1:0]               alu_vld_in;
   logic     [W_PORTS-1:0][WORD_W-1:0]   alu_res;
   logic     [W_PORTS-1:0]               alu_mask_in;
   logic     [W_PORTS-1:0][WORD_W-1:0]     vs1_data;
   logic     [W_PORTS-1:0][WORD_W-1:0]     vs2_data;
   logic     [W_PORTS-1:0][ALU_CTRL_W-1:0] alu_opmode;
   logic     [W_PORTS-1:0][1:0]            alu_read_sew;
   logic     [W_PORTS-1:0][1:0]            alu_write_sew;
   logic     [W_PORTS-1:0]                 alu_vld_out;
   int                                   cycle_cnt;

   // Reference model of the register file and the mask bits
   logic     [WORD_W-1:0]                mdl_mem [VRF_DEPTH];
   logic     [MASK_DEPTH-1:0]            mdl_mask;

   vector_lane u_vector_lane (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .rd_req_i        (rd_req),
      .alu_req_i       (alu_req),
      .wr_req_i        (wr_req),
      .load_data_i     (load_data),
      .alu_vld_i       (alu_vld_in),
      .alu_res_i       (alu_res),
      .alu_mask_i      (alu_mask_in),
      .vs1_data_o      (vs1_data),
      .vs2_data_o      (vs2_data),
      .alu_opmode_o    (alu_opmode),
      .alu_read_sew_o  (alu_read_sew),
      .alu_write_sew_o (alu_write_sew),
      .alu_vld_o       (alu_vld_out)
   );

   always #10 clk_i = ~clk_i;

   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Run stopped after %0d cycles before the tests were done", cycle_cnt);
         $display("Test failed");
         $fatal(1, "timeout");
      end
   end

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////

   task automatic check_val(input string name, input logic [WORD_W-1:0] exp,
                            input logic [WORD_W-1:0] act);
      assert (act === exp) else begin
         $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
         $display("Test failed");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   task automatic next_cycle();
      @(posedge clk_i);
      #1;
   endtask

   task automatic idle_inputs();
      rd_req      = '0;
      alu_req     = '0;
      wr_req      = '0;
      load_data   = '0;
      alu_vld_in  = '0;
      alu_res     = '0;
      alu_mask_in = '0;
   endtask

   // Every byte depends on the whole address
   function automatic logic [WORD_W-1:0] fill_word(input logic [WORD_W-1:0] a);
      return (a * 32'h0103_0507) ^ 32'h5ac3_0f96;
   endfunction

   function automatic logic [WORD_W-1:0] expect_elem(input logic [WORD_W-1:0] w,
                                                     input logic [1:0] sew,
                                                     input logic [1:0] sel);
      vreg_word_u u;
      u.word = w;
      case (sew)
         SEW8:    return {24'h0, u.bytes[sel]};
         SEW16:   return {16'h0, u.halves[sel[0]]};
         default: return w;
      endcase
   endfunction

   function automatic rd_req_t make_rd(input logic [VRF_ADDR_W-1:0] addr,
                                       input logic [1:0] sel);
      rd_req_t r;
      r.en       = 1'b1;
      r.addr     = addr;
      r.elem_sel = sel;
      return r;
   endfunction

   function automatic alu_req_t make_alu(input logic [1:0] rsew);
      alu_req_t a;
      a.vld       = 1'b1;
      a.opmode    = ALU_CTRL_W'($urandom());
      a.read_sew  = rsew;
      a.write_sew = 2'($urandom_range(2, 0));
      return a;
   endfunction

   function automatic wr_req_t make_wr(input logic [VRF_ADDR_W-1:0] addr,
                                       input logic [BE_W-1:0] be, input logic src,
                                       input logic masked, input logic req_ctrl,
                                       input logic [MASK_ADDR_W-1:0] mask_addr);
      wr_req_t w;
      w.addr      = addr;
      w.be        = be;
      w.src_sel   = src;
      w.masked    = masked;
      w.req_ctrl  = req_ctrl;
      w.mask_we   = 1'b0;
      w.mask_addr = mask_addr;
      return w;
   endfunction

   // Mask bits are taken before either port commits its mask write
   task automatic model_commit();
      logic [W_PORTS-1:0]           gate;
      logic [W_PORTS-1:0][BE_W-1:0] be_eff;
      logic [WORD_W-1:0]            data;
      for (int j = 0; j < W_PORTS; j++) begin
         gate[j]   = alu_vld_in[j] | wr_req[j].req_ctrl;
         be_eff[j] = wr_req[j].be & {BE_W{gate[j]}};
         if (wr_req[j].masked) begin
            be_eff[j] = be_eff[j] & {BE_W{mdl_mask[wr_req[j].mask_addr]}};
         end
      end
      // Port 1 applied last, so it wins on a shared byte
      for (int j = 0; j < W_PORTS; j++) begin
         data = (wr_req[j].src_sel == SRC_LOAD) ? load_data : alu_res[j];
         for (int b = 0; b < BE_W; b++) begin
            if (be_eff[j][b]) begin
               mdl_mem[wr_req[j].addr][b*8 +: 8] = data[b*8 +: 8];
            end
         end
      end
      for (int j = 0; j < W_PORTS; j++) begin
         if (wr_req[j].mask_we && gate[j]) begin
            mdl_mask[wr_req[j].mask_addr] = alu_mask_in[j];
         end
      end
   endtask

   task automatic send_writes();
      model_commit();
      next_cycle();
      wr_req      = '0;
      load_data   = '0;
      alu_vld_in  = '0;
      alu_res     = '0;
      alu_mask_in = '0;
   endtask

   task automatic wait_commit();
      repeat (COMMIT_LATENCY) next_cycle();
   endtask

   // Operands and control show up two cycles after the request
   task automatic read_check(input rd_req_t [R_PORTS-1:0] req,
                             input alu_req_t [W_PORTS-1:0] areq);
      logic [R_PORTS-1:0][WORD_W-1:0] exp;
      for (int i = 0; i < R_PORTS; i++) begin
         exp[i] = expect_elem(mdl_mem[req[i].addr], areq[i/2].read_sew, req[i].elem_sel);
      end
      rd_req  = req;
      alu_req = areq;
      next_cycle();
      rd_req  = '0;
      alu_req = '0;
      check_val("alu_vld_o", 32'd0, 32'(alu_vld_out));
      next_cycle();
      for (int j = 0; j < W_PORTS; j++) begin
         check_val($sformatf("vs1_data_o[%0d]", j), exp[2*j], vs1_data[j]);
         check_val($sformatf("vs2_data_o[%0d]", j), exp[2*j+1], vs2_data[j]);
         check_val($sformatf("alu_vld_o[%0d]", j), 32'(areq[j].vld), 32'(alu_vld_out[j]));
         check_val($sformatf("alu_opmode_o[%0d]", j), 32'(areq[j].opmode),
                   32'(alu_opmode[j]));
         check_val($sformatf("alu_read_sew_o[%0d]", j), 32'(areq[j].read_sew),
                   32'(alu_read_sew[j]));
         check_val($sformatf("alu_write_sew_o[%0d]", j), 32'(areq[j].write_sew),
                   32'(alu_write_sew[j]));
      end
   endtask

   task automatic read_word(input logic [VRF_ADDR_W-1:0] addr);
      rd_req_t  [R_PORTS-1:0] req;
      alu_req_t [W_PORTS-1:0] areq;
      for (int i = 0; i < R_PORTS; i++) req[i] = make_rd(addr, 2'd0);
      for (int j = 0; j < W_PORTS; j++) areq[j] = make_alu(SEW32);
      read_check(req, areq);
   endtask

   //////////////////////////////////////////////////
   // Tests
   //////////////////////////////////////////////////

   task automatic fill_and_readback();
      rd_req_t  [R_PORTS-1:0] req;
      alu_req_t [W_PORTS-1:0] areq;
      // Port 0 loads under request control, port 1 takes the ALU result
      for (int a = 0; a < VRF_DEPTH; a += 2) begin
         wr_req[0]  = make_wr(VRF_ADDR_W'(a), 4'hf, SRC_LOAD, 1'b0, 1'b1, '0);
         wr_req[1]  = make_wr(VRF_ADDR_W'(a + 1), 4'hf, SRC_ALU, 1'b0, 1'b0, '0);
         load_data  = fill_word(a);
         alu_res[1] = fill_word(a + 1);
         alu_vld_in = 2'b10;
         send_writes();
      end
      wait_commit();
      for (int a = 0; a < VRF_DEPTH; a += R_PORTS) begin
         for (int i = 0; i < R_PORTS; i++) req[i] = make_rd(VRF_ADDR_W'(a + i), 2'd0);
         for (int j = 0; j < W_PORTS; j++) areq[j] = make_alu(SEW32);
         read_check(req, areq);
      end
   endtask

   task automatic extract_elements();
      rd_req_t  [R_PORTS-1:0] req;
      alu_req_t [W_PORTS-1:0] areq;
      wr_req[0] = make_wr(6'd5, 4'hf, SRC_LOAD, 1'b0, 1'b1, '0);
      load_data = 32'hc3a5_7e19;
      send_writes();
      wait_commit();
      for (int i = 0; i < R_PORTS; i++) req[i] = make_rd(6'd5, 2'(i));
      for (int j = 0; j < W_PORTS; j++) areq[j] = make_alu(SEW8);
      read_check(req, areq);
      for (int j = 0; j < W_PORTS; j++) areq[j] = make_alu(SEW16);
      read_check(req, areq);
   endtask

   task automatic alu_gating();
      wr_req[0]  = make_wr(6'd9, 4'b0101, SRC_ALU, 1'b0, 1'b0, '0);
      alu_vld_in = 2'b01;
      alu_res[0] = 32'h1122_3344;
      send_writes();
      wait_commit();
      read_word(6'd9);
      // No ALU valid and no request control
      wr_req[0]  = make_wr(6'd9, 4'hf, SRC_ALU, 1'b0, 1'b0, '0);
      alu_res[0] = 32'hdead_beef;
      send_writes();
      wait_commit();
      read_word(6'd9);
   endtask

   task automatic set_mask(input logic [MASK_ADDR_W-1:0] maddr, input logic bit_val);
      wr_req[1]         = make_wr(6'd0, 4'h0, SRC_ALU, 1'b0, 1'b0, maddr);
      wr_req[1].mask_we = 1'b1;
      alu_vld_in        = 2'b10;
      alu_mask_in[1]    = bit_val;
      send_writes();
      wait_commit();
   endtask

   task automatic masked_load(input logic [WORD_W-1:0] data);
      wr_req[0] = make_wr(6'd12, 4'hf, SRC_LOAD, 1'b1, 1'b1, 5'd3);
      load_data = data;
      send_writes();
      wait_commit();
      read_word(6'd12);
   endtask

   task automatic masking();
      masked_load(32'h0bad_f00d);
      set_mask(5'd3, 1'b1);
      masked_load(32'h600d_cafe);
      set_mask(5'd3, 1'b0);
      masked_load(32'h7777_0001);
   endtask

   task automatic random_traffic();
      rd_req_t  [R_PORTS-1:0] req;
      alu_req_t [W_PORTS-1:0] areq;
      for (int n = 0; n < 100; n++) begin
         for (int j = 0; j < W_PORTS; j++) begin
            wr_req[j] = make_wr(VRF_ADDR_W'($urandom()), BE_W'($urandom()),
                                1'($urandom()), 1'($urandom()), 1'($urandom()),
                                MASK_ADDR_W'($urandom_range(3, 0)));
            wr_req[j].mask_we = 1'($urandom());
            alu_res[j]        = $urandom();
         end
         // Roughly one in four lands both ports on one word
         if ($urandom_range(3, 0) == 0) wr_req[1].addr = wr_req[0].addr;
         alu_vld_in  = W_PORTS'($urandom());
         alu_mask_in = W_PORTS'($urandom());
         load_data   = $urandom();
         req[0] = make_rd(wr_req[0].addr, 2'($urandom()));
         req[1] = make_rd(wr_req[1].addr, 2'($urandom()));
         req[2] = make_rd(VRF_ADDR_W'($urandom()), 2'($urandom()));
         req[3] = make_rd(VRF_ADDR_W'($urandom()), 2'($urandom()));
         send_writes();
         wait_commit();
         for (int j = 0; j < W_PORTS; j++) areq[j] = make_alu(2'($urandom_range(2, 0)));
         read_check(req, areq);
      end
   endtask

   initial begin
      void'($urandom(32'hd83efbc2));
      clk_i     = 1'b0;
      rst_i     = 1'b0;
      cycle_cnt = 0;
      mdl_mask  = '0;
      idle_inputs();
      repeat (10) @(posedge clk_i);
      #1;
      rst_i = 1'b1;
      fill_and_readback();
      extract_elements();
      alu_gating();
      masking();
      random_traffic();
      $display("Test completed successfully");
      $finish;
   end

endmodule

`default_nettype wire
